// ==== masku_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// Mask unit configuration
//////////////////////////////////////////////////////////////////////

`ifndef MASKU_CFG_SVH
`define MASKU_CFG_SVH

// Lane count and lane datapath width
`define MASKU_NR_LANES 2
`define MASKU_ELEN     64

// Vector length and counters, instruction id, VRF word address
`define MASKU_VL_W     10
`define MASKU_VID_W    3
`define MASKU_ADDR_W   8

// Result queue entries
`define MASKU_RQ_DEPTH 2

`endif

// ==== masku_if.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit internal interfaces
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

// Current instruction from control to the merge stage
interface masku_insn_if;
  import masku_pkg::*;

  logic   valid;
  vid_t   id;
  vlen_t  vl;
  vaddr_t vd;
  logic   vm;
  // Index k of the word being issued
  vlen_t  word_idx;
  // Pulse, one word pushed into the queue
  logic   word_done;

  modport ctrl  (output valid, id, vl, vd, vm, word_idx, input word_done);
  modport merge (input valid, id, vl, vd, vm, word_idx, output word_done);
endinterface

// Merged words from the merge stage to the result queue
interface masku_res_if;
  import masku_pkg::*;

  logic       valid;
  logic       ready;
  word_t      wdata;
  word_strb_t be;
  vaddr_t     addr;
  vid_t       id;

  modport src (output valid, wdata, be, addr, id, input ready);
  modport dst (input valid, wdata, be, addr, id, output ready);
endinterface

// ==== masku_insn_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit instruction control
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "masku_cfg.svh"

module masku_insn_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  masku_pkg::vid_t   req_id_i,
  input  masku_pkg::vlen_t  req_vl_i,
  input  masku_pkg::vaddr_t req_vd_i,
  input  logic              req_vm_i,
  masku_insn_if.ctrl        insn,
  input  logic              pop_i,
  output logic              done_o,
  output masku_pkg::vid_t   done_id_o
);
  import masku_pkg::*;

  localparam int unsigned WordBits = `MASKU_NR_LANES * `MASKU_ELEN;

  ctrl_state_e state_q;

  // Accepted instruction
  vid_t   id_q;
  vlen_t  vl_q;
  vaddr_t vd_q;
  logic   vm_q;

  // Words left to issue and to commit, index of the next word
  vlen_t issue_cnt_q, commit_cnt_q, commit_cnt_d, word_idx_q;
  vlen_t nr_words;
  logic  accept, last_pop;

  // ceil(vl / word width), done in 32 bits so vl+127 cannot wrap
  assign nr_words = vlen_t'((32'(req_vl_i) + WordBits - 1) / WordBits);

  assign req_ready_o = (state_q == CTRL_IDLE);
  assign accept      = req_ready_o && req_valid_i;

  assign commit_cnt_d = pop_i ? commit_cnt_q - vlen_t'(1) : commit_cnt_q;
  // Last word granted on every lane
  assign last_pop     = (state_q == CTRL_DRAIN) && pop_i && (commit_cnt_d == '0);

  // Drive the merge stage
  assign insn.valid    = (state_q == CTRL_ISSUE);
  assign insn.id       = id_q;
  assign insn.vl       = vl_q;
  assign insn.vd       = vd_q;
  assign insn.vm       = vm_q;
  assign insn.word_idx = word_idx_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= CTRL_IDLE;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      word_idx_q   <= '0;
      done_o       <= 1'b0;
    end else begin
      done_o       <= last_pop;
      commit_cnt_q <= commit_cnt_d;
      unique case (state_q)
        CTRL_IDLE: begin
          if (accept) begin
            issue_cnt_q  <= nr_words;
            commit_cnt_q <= nr_words;
            word_idx_q   <= '0;
            state_q      <= CTRL_ISSUE;
          end
        end
        CTRL_ISSUE: begin
          if (insn.word_done) begin
            issue_cnt_q <= issue_cnt_q - vlen_t'(1);
            word_idx_q  <= word_idx_q + vlen_t'(1);
            // Final word pushed, wait for writeback
            if (issue_cnt_q == vlen_t'(1)) state_q <= CTRL_DRAIN;
          end
        end
        CTRL_DRAIN: begin
          if (last_pop) state_q <= CTRL_IDLE;
        end
        default: state_q <= CTRL_IDLE;
      endcase
    end
  end

  // Instruction fields and done id
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q <= req_id_i;
      vl_q <= req_vl_i;
      vd_q <= req_vd_i;
      vm_q <= req_vm_i;
    end
    if (last_pop) done_id_o <= id_q;
  end

endmodule

// ==== masku_merge.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit merge stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "masku_cfg.svh"

module masku_merge (
  input  masku_pkg::word_t operand_a_i,
  input  masku_pkg::word_t operand_b_i,
  input  masku_pkg::word_t operand_m_i,
  input  logic             operand_a_valid_i,
  input  logic             operand_b_valid_i,
  input  logic             operand_m_valid_i,
  output logic             operand_a_ready_o,
  output logic             operand_b_ready_o,
  output logic             operand_m_ready_o,
  masku_insn_if.merge      insn,
  masku_res_if.src         res
);
  import masku_pkg::*;

  // Per lane slices of the word being merged
  vlen_t [`MASKU_NR_LANES-1:0] lane_base;
  vlen_t [`MASKU_NR_LANES-1:0] lane_rem;
  elen_t [`MASKU_NR_LANES-1:0] lane_en;
  elen_t [`MASKU_NR_LANES-1:0] lane_res;
  strb_t [`MASKU_NR_LANES-1:0] lane_be;
  vlen_t word_base;
  logic  ops_valid, push;

  // First element index of word k
  assign word_base = vlen_t'(insn.word_idx * (`MASKU_NR_LANES * `MASKU_ELEN));

  always_comb begin
    for (int l = 0; l < `MASKU_NR_LANES; l++) begin
      lane_base[l] = word_base + vlen_t'(l * `MASKU_ELEN);
      // Body elements still left from the start of this lane
      lane_rem[l]  = (insn.vl > lane_base[l]) ? insn.vl - lane_base[l] : '0;

      // Tail enable, full lane or the low lane_rem bits
      if (lane_rem[l] >= vlen_t'(`MASKU_ELEN)) lane_en[l] = '1;
      else lane_en[l] = (elen_t'(1) << lane_rem[l]) - elen_t'(1);
      // Predicate from the mask operand
      if (!insn.vm) lane_en[l] = lane_en[l] & operand_m_i[l*`MASKU_ELEN +: `MASKU_ELEN];

      // Bit blend, a where enabled, old vd elsewhere
      lane_res[l] = (operand_a_i[l*`MASKU_ELEN +: `MASKU_ELEN] & lane_en[l]) |
                    (operand_b_i[l*`MASKU_ELEN +: `MASKU_ELEN] & ~lane_en[l]);

      // Bytes that hold any element below vl
      if (lane_rem[l] >= vlen_t'(`MASKU_ELEN)) lane_be[l] = '1;
      else lane_be[l] = (strb_t'(1) << ((lane_rem[l] + 7) >> 3)) - strb_t'(1);
    end
  end

  // Needed operands, m only when masked
  assign ops_valid = operand_a_valid_i && operand_b_valid_i && (insn.vm || operand_m_valid_i);
  assign res.valid = insn.valid && ops_valid;
  assign push      = res.valid && res.ready;

  // Operands leave together with the push
  assign operand_a_ready_o = push;
  assign operand_b_ready_o = push;
  assign operand_m_ready_o = push && !insn.vm;
  assign insn.word_done    = push;

  assign res.wdata = lane_res;
  assign res.be    = lane_be;
  assign res.addr  = insn.vd + vaddr_t'(insn.word_idx);
  assign res.id    = insn.id;

endmodule

// ==== masku_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit types
//////////////////////////////////////////////////////////////////////

`include "masku_cfg.svh"

package masku_pkg;

  // One lane word and its byte strobes
  typedef logic [`MASKU_ELEN-1:0]   elen_t;
  typedef logic [`MASKU_ELEN/8-1:0] strb_t;

  // Full VRF word, lane 0 in the low bits
  typedef logic [`MASKU_NR_LANES*`MASKU_ELEN-1:0]   word_t;
  typedef logic [`MASKU_NR_LANES*`MASKU_ELEN/8-1:0] word_strb_t;

  // Vector length, also used for the word counters
  typedef logic [`MASKU_VL_W-1:0]   vlen_t;
  typedef logic [`MASKU_VID_W-1:0]  vid_t;
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;

  // One bit per lane
  typedef logic [`MASKU_NR_LANES-1:0] lane_vec_t;

  // Control FSM
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_ISSUE,
    CTRL_DRAIN
  } ctrl_state_e;

endpackage

// ==== masku_result_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit result queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module masku_result_queue #(
  parameter int unsigned Depth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  masku_res_if.dst              res,
  output masku_pkg::lane_vec_t  result_req_o,
  output masku_pkg::word_t      result_wdata_o,
  output masku_pkg::word_strb_t result_be_o,
  output masku_pkg::vaddr_t     result_addr_o,
  output masku_pkg::vid_t       result_id_o,
  input  masku_pkg::lane_vec_t  result_gnt_i,
  output logic                  pop_o
);
  import masku_pkg::*;

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  // Entry payload
  word_t      wdata_q [Depth];
  word_strb_t be_q    [Depth];
  vaddr_t     addr_q  [Depth];
  vid_t       id_q    [Depth];
  // Lanes still waiting for a grant, per entry
  lane_vec_t  pending_q [Depth];
  lane_vec_t  head_pending_d;

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push, empty;

  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty     = (cnt_q == '0);
  assign res.ready = (cnt_q != CntW'(Depth));
  assign push      = res.valid && res.ready;

  // Head entry on all lanes
  assign result_req_o   = pending_q[rd_ptr_q];
  assign result_wdata_o = wdata_q[rd_ptr_q];
  assign result_be_o    = be_q[rd_ptr_q];
  assign result_addr_o  = addr_q[rd_ptr_q];
  assign result_id_o    = id_q[rd_ptr_q];

  // Pop in the cycle of the last grant
  assign head_pending_d = pending_q[rd_ptr_q] & ~result_gnt_i;
  assign pop_o          = !empty && (head_pending_d == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < Depth; i++) pending_q[i] <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      pending_q[rd_ptr_q] <= head_pending_d;
      // Write pointer never equals a busy head, so the push wins cleanly
      if (push) begin
        pending_q[wr_ptr_q] <= '1;
        wr_ptr_q            <= ptr_next(wr_ptr_q);
      end
      if (pop_o) rd_ptr_q <= ptr_next(rd_ptr_q);
      if (push && !pop_o) cnt_q <= cnt_q + 1'b1;
      else if (pop_o && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      wdata_q[wr_ptr_q] <= res.wdata;
      be_q[wr_ptr_q]    <= res.be;
      addr_q[wr_ptr_q]  <= res.addr;
      id_q[wr_ptr_q]    <= res.id;
    end
  end

endmodule

// ==== masku_top.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit top level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "masku_cfg.svh"

module masku_top #(
  parameter int unsigned RqDepth = `MASKU_RQ_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Instruction request
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  masku_pkg::vid_t       req_id_i,
  input  masku_pkg::vlen_t      req_vl_i,
  input  masku_pkg::vaddr_t     req_vd_i,
  input  logic                  req_vm_i,
  // Operands a, b and m
  input  masku_pkg::word_t      operand_a_i,
  input  logic                  operand_a_valid_i,
  output logic                  operand_a_ready_o,
  input  masku_pkg::word_t      operand_b_i,
  input  logic                  operand_b_valid_i,
  output logic                  operand_b_ready_o,
  input  masku_pkg::word_t      operand_m_i,
  input  logic                  operand_m_valid_i,
  output logic                  operand_m_ready_o,
  // Lane writeback
  output masku_pkg::lane_vec_t  result_req_o,
  output masku_pkg::word_t      result_wdata_o,
  output masku_pkg::word_strb_t result_be_o,
  output masku_pkg::vaddr_t     result_addr_o,
  output masku_pkg::vid_t       result_id_o,
  input  masku_pkg::lane_vec_t  result_gnt_i,
  // Completion
  output logic                  done_o,
  output masku_pkg::vid_t       done_id_o
);

  masku_insn_if u_insn_if ();
  masku_res_if  u_res_if ();

  logic pop;

  ////////////////////////////////////////////////////////////////////
  // Control, merge, result queue
  ////////////////////////////////////////////////////////////////////

  masku_insn_ctrl u_insn_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_id_i    (req_id_i),
    .req_vl_i    (req_vl_i),
    .req_vd_i    (req_vd_i),
    .req_vm_i    (req_vm_i),
    .insn        (u_insn_if.ctrl),
    .pop_i       (pop),
    .done_o      (done_o),
    .done_id_o   (done_id_o)
  );

  masku_merge u_merge (
    .operand_a_i       (operand_a_i),
    .operand_b_i       (operand_b_i),
    .operand_m_i       (operand_m_i),
    .operand_a_valid_i (operand_a_valid_i),
    .operand_b_valid_i (operand_b_valid_i),
    .operand_m_valid_i (operand_m_valid_i),
    .operand_a_ready_o (operand_a_ready_o),
    .operand_b_ready_o (operand_b_ready_o),
    .operand_m_ready_o (operand_m_ready_o),
    .insn              (u_insn_if.merge),
    .res               (u_res_if.src)
  );

  masku_result_queue #(
    .Depth (RqDepth)
  ) u_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .res            (u_res_if.dst),
    .result_req_o   (result_req_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_gnt_i   (result_gnt_i),
    .pop_o          (pop)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mask unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_masku \
  -f sources.f -Mdir obj_dir -o sim_masku > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_masku > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== sources.f ====
+incdir+.
masku_pkg.sv
masku_if.sv
masku_insn_ctrl.sv
masku_merge.sv
masku_result_queue.sv
masku_top.sv
tb_masku_assertions.sv
tb_masku_checker.sv
tb_masku.sv

// ==== tb_masku.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "masku_cfg.svh"

module tb_masku;
  import masku_pkg::*;

  localparam int NrStim  = 7;
  localparam int Timeout = 1000;

  // Instruction fields, grant mode, expected word count
  typedef struct packed {
    vid_t   id;
    vlen_t  vl;
    vaddr_t vd;
    logic   vm;
    logic   rand_gnt;
    vlen_t  words;
  } stim_t;

  stim_t stim_tab [NrStim] = '{
    '{3'd1, 10'd256,  8'h10, 1'b1, 1'b0, 10'd2},
    '{3'd2, 10'd200,  8'h20, 1'b1, 1'b0, 10'd2},
    '{3'd3, 10'd384,  8'h30, 1'b0, 1'b0, 10'd3},
    '{3'd4, 10'd300,  8'h40, 1'b0, 1'b1, 10'd3},
    // Address wraps past the top of the VRF
    '{3'd5, 10'd512,  8'hfe, 1'b1, 1'b1, 10'd4},
    '{3'd6, 10'd1,    8'h00, 1'b0, 1'b1, 10'd1},
    '{3'd7, 10'd1023, 8'h80, 1'b0, 1'b1, 10'd8}
  };

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  logic       req_ready_o;
  vid_t       req_id_i;
  vlen_t      req_vl_i;
  vaddr_t     req_vd_i;
  logic       req_vm_i;
  word_t      operand_a_i, operand_b_i, operand_m_i;
  logic       operand_a_valid_i, operand_b_valid_i, operand_m_valid_i;
  logic       operand_a_ready_o, operand_b_ready_o, operand_m_ready_o;
  lane_vec_t  result_req_o;
  word_t      result_wdata_o;
  word_strb_t result_be_o;
  vaddr_t     result_addr_o;
  vid_t       result_id_o;
  lane_vec_t  result_gnt_i = '0;
  logic       done_o;
  vid_t       done_id_o;

  // Grant mode of the running entry
  logic        rand_gnt = 1'b0;
  int unsigned data_errs, proto_errs;
  int unsigned timeouts = 0;

  masku_top u_masku_top (.*);

  tb_masku_checker u_checker (.*, .data_err_o(data_errs), .proto_err_o(proto_errs));

  always #5 clk_i = ~clk_i;

  // Lane grants, withheld at random per lane in back-pressure entries
  always @(posedge clk_i) begin
    #1;
    for (int l = 0; l < `MASKU_NR_LANES; l++) begin
      result_gnt_i[l] = rst_ni && (!rand_gnt || ($urandom % 3 == 0));
    end
  end

  function automatic word_t random_word();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  // One operand beat after a random gap
  task automatic drive_word(input logic vm);
    int gap;
    int cnt;
    gap = $urandom % 3;
    repeat (gap) begin
      @(posedge clk_i);
      #1;
    end
    operand_a_i       = random_word();
    operand_b_i       = random_word();
    operand_m_i       = random_word();
    operand_a_valid_i = 1'b1;
    operand_b_valid_i = 1'b1;
    operand_m_valid_i = !vm;
    cnt = 0;
    @(negedge clk_i);
    while (!operand_a_ready_o && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!operand_a_ready_o) report_timeout("operand ready");
    @(posedge clk_i);
    #1;
    operand_a_valid_i = 1'b0;
    operand_b_valid_i = 1'b0;
    operand_m_valid_i = 1'b0;
  endtask

  // Issue one table row and feed it until done
  task automatic run_insn(input stim_t s);
    int cnt;
    @(posedge clk_i);
    #1;
    rand_gnt    = s.rand_gnt;
    req_valid_i = 1'b1;
    req_id_i    = s.id;
    req_vl_i    = s.vl;
    req_vd_i    = s.vd;
    req_vm_i    = s.vm;
    cnt = 0;
    @(negedge clk_i);
    while (!req_ready_o && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!req_ready_o) begin
      report_timeout("instruction acceptance");
      return;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    for (int w = 0; w < int'(s.words) && timeouts == 0; w++) drive_word(s.vm);
    if (timeouts != 0) return;
    cnt = 0;
    @(negedge clk_i);
    while (!done_o && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!done_o) report_timeout("done pulse");
  endtask

  initial begin
    void'($urandom(32'h4f86));
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_id_i          = '0;
    req_vl_i          = '0;
    req_vd_i          = '0;
    req_vm_i          = 1'b1;
    operand_a_i       = '0;
    operand_b_i       = '0;
    operand_m_i       = '0;
    operand_a_valid_i = 1'b0;
    operand_b_valid_i = 1'b0;
    operand_m_valid_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < NrStim && timeouts == 0; i++) run_insn(stim_tab[i]);
    repeat (4) @(posedge clk_i);
    $display("Errors: %0d data, %0d protocol, %0d timeouts", data_errs, proto_errs, timeouts);
    if (data_errs == 0 && proto_errs == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== tb_masku_assertions.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit protocol assertions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "masku_cfg.svh"

module tb_masku_assertions (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  req_ready_o,
  input logic                  operand_a_ready_o,
  input logic                  operand_b_ready_o,
  input logic                  operand_m_ready_o,
  input masku_pkg::lane_vec_t  result_req_o,
  input masku_pkg::lane_vec_t  result_gnt_i,
  input masku_pkg::word_t      result_wdata_o,
  input masku_pkg::word_strb_t result_be_o,
  input masku_pkg::vaddr_t     result_addr_o,
  input logic                  done_o
);

  localparam int LaneBits  = `MASKU_ELEN;
  localparam int LaneBytes = `MASKU_ELEN / 8;

  // Done is a single cycle pulse
  done_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o)
    else $error("done_o stayed high for two cycles");

  // Idle control stage consumes no operands
  no_operands_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_ready_o |-> !(operand_a_ready_o || operand_b_ready_o || operand_m_ready_o))
    else $error("operand ready high while req_ready_o is high");

  // Ungranted lane request keeps its word
  for (genvar l = 0; l < `MASKU_NR_LANES; l++) begin : gen_lane
    req_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l] &&
      $stable(result_wdata_o[l*LaneBits +: LaneBits]) &&
      $stable(result_be_o[l*LaneBytes +: LaneBytes]) && $stable(result_addr_o))
      else $error("lane %0d request dropped or changed before its grant", l);
  end

endmodule

bind masku_top tb_masku_assertions u_assertions (.*);

// ==== tb_masku_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Mask unit result checker
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "masku_cfg.svh"

module tb_masku_checker (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_valid_i,
  input  logic                  req_ready_o,
  input  masku_pkg::vid_t       req_id_i,
  input  masku_pkg::vlen_t      req_vl_i,
  input  masku_pkg::vaddr_t     req_vd_i,
  input  logic                  req_vm_i,
  input  masku_pkg::word_t      operand_a_i,
  input  masku_pkg::word_t      operand_b_i,
  input  masku_pkg::word_t      operand_m_i,
  input  logic                  operand_a_valid_i,
  input  logic                  operand_b_valid_i,
  input  logic                  operand_m_valid_i,
  input  logic                  operand_a_ready_o,
  input  logic                  operand_b_ready_o,
  input  logic                  operand_m_ready_o,
  input  masku_pkg::lane_vec_t  result_req_o,
  input  masku_pkg::word_t      result_wdata_o,
  input  masku_pkg::word_strb_t result_be_o,
  input  masku_pkg::vaddr_t     result_addr_o,
  input  masku_pkg::vid_t       result_id_o,
  input  masku_pkg::lane_vec_t  result_gnt_i,
  input  logic                  done_o,
  input  masku_pkg::vid_t       done_id_o,
  output int unsigned           data_err_o,
  output int unsigned           proto_err_o
);
  import masku_pkg::*;

  localparam int WordBits  = `MASKU_NR_LANES * `MASKU_ELEN;
  localparam int WordBytes = WordBits / 8;
  localparam int LaneBits  = `MASKU_ELEN;
  localparam int LaneBytes = LaneBits / 8;

  int unsigned data_errs  = 0;
  int unsigned proto_errs = 0;
  int          rst_cycles = 0;

  // Predicted words, oldest first
  word_t      exp_data [$];
  word_strb_t exp_be   [$];
  vaddr_t     exp_addr [$];

  // Instruction in flight
  vid_t      cur_id;
  vlen_t     cur_vl;
  vaddr_t    cur_vd;
  logic      cur_vm;
  logic      busy;
  int        word_k, commit_cnt, nr_words;
  lane_vec_t granted;

  assign data_err_o  = data_errs;
  assign proto_err_o = proto_errs;

  task automatic report_mismatch(input string msg);
    data_errs++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  task automatic report_protocol(input string msg);
    proto_errs++;
    $display("Protocol error at %0t: %s", $time, msg);
  endtask

  // Bit j of word k takes a when element k*128+j is in the body and unmasked
  function automatic word_t predict_data(input word_t a, b, m, input int vl,
                                         input logic vm, input int k);
    word_t r;
    logic  en;
    for (int j = 0; j < WordBits; j++) begin
      en   = (k * WordBits + j < vl) && (vm || m[j]);
      r[j] = en ? a[j] : b[j];
    end
    return r;
  endfunction

  // Byte i of word k written when it lies below ceil(vl/8)
  function automatic word_strb_t predict_strb(input int vl, input int k);
    word_strb_t s;
    for (int i = 0; i < WordBytes; i++) begin
      s[i] = (k * WordBytes + i) < (vl + 7) / 8;
    end
    return s;
  endfunction

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      rst_cycles++;
      if (rst_cycles > 1 && (!req_ready_o || operand_a_ready_o || operand_b_ready_o ||
          operand_m_ready_o || result_req_o != '0 || done_o))
        report_protocol("outputs are not at their reset values during reset");
      busy    = 1'b0;
      granted = '0;
      word_k  = 0;
      exp_data.delete();
      exp_be.delete();
      exp_addr.delete();
    end else begin
      ////////////////////////////////////////////////////////////////
      // Operand beats
      ////////////////////////////////////////////////////////////////
      if (operand_a_ready_o || operand_b_ready_o || operand_m_ready_o) begin
        if (!busy) report_protocol("operands consumed with no instruction in flight");
        // a and b always together, m only for masked instructions
        if (!(operand_a_ready_o && operand_b_ready_o) || operand_m_ready_o != !cur_vm)
          report_protocol("operand ready outputs do not match the needed operands");
        if (!operand_a_valid_i || !operand_b_valid_i || (!cur_vm && !operand_m_valid_i))
          report_protocol("operand consumed while not valid");
        exp_data.push_back(predict_data(operand_a_i, operand_b_i, operand_m_i,
                                        int'(cur_vl), cur_vm, word_k));
        exp_be.push_back(predict_strb(int'(cur_vl), word_k));
        exp_addr.push_back(vaddr_t'(int'(cur_vd) + word_k));
        word_k++;
      end

      ////////////////////////////////////////////////////////////////
      // Lane writeback
      ////////////////////////////////////////////////////////////////
      for (int l = 0; l < `MASKU_NR_LANES; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          if (exp_data.size() == 0) begin
            report_protocol($sformatf("lane %0d wrote a word that was never fed", l));
          end else begin
            if (result_wdata_o[l*LaneBits +: LaneBits] !== exp_data[0][l*LaneBits +: LaneBits])
              report_mismatch($sformatf("lane %0d data %h, expected %h", l,
                result_wdata_o[l*LaneBits +: LaneBits], exp_data[0][l*LaneBits +: LaneBits]));
            if (result_be_o[l*LaneBytes +: LaneBytes] !== exp_be[0][l*LaneBytes +: LaneBytes])
              report_mismatch($sformatf("lane %0d strobes %b, expected %b", l,
                result_be_o[l*LaneBytes +: LaneBytes], exp_be[0][l*LaneBytes +: LaneBytes]));
            if (result_addr_o !== exp_addr[0] || result_id_o !== cur_id)
              report_mismatch($sformatf("lane %0d addr %h id %0d, expected addr %h id %0d",
                l, result_addr_o, result_id_o, exp_addr[0], cur_id));
          end
          granted[l] = 1'b1;
        end
      end
      // Word retired once every lane took it
      if (&granted) begin
        if (exp_data.size() != 0) begin
          void'(exp_data.pop_front());
          void'(exp_be.pop_front());
          void'(exp_addr.pop_front());
        end
        granted = '0;
        commit_cnt++;
      end

      ////////////////////////////////////////////////////////////////
      // Completion and readiness
      ////////////////////////////////////////////////////////////////
      if (done_o) begin
        if (!busy) begin
          report_protocol("done_o pulsed with no instruction in flight");
        end else begin
          nr_words = (int'(cur_vl) + WordBits - 1) / WordBits;
          if (done_id_o !== cur_id)
            report_mismatch($sformatf("done id %0d, expected %0d", done_id_o, cur_id));
          if (commit_cnt != nr_words)
            report_mismatch($sformatf("%0d words written, expected %0d", commit_cnt, nr_words));
          if (exp_data.size() != 0) report_protocol("done_o before all words were written");
          if (!req_ready_o) report_protocol("req_ready_o low in the cycle of done_o");
        end
        busy = 1'b0;
      end else if (busy && req_ready_o) begin
        report_protocol("req_ready_o high while an instruction is in flight");
      end

      if (req_valid_i && req_ready_o) begin
        cur_id     = req_id_i;
        cur_vl     = req_vl_i;
        cur_vd     = req_vd_i;
        cur_vm     = req_vm_i;
        busy       = 1'b1;
        word_k     = 0;
        commit_cnt = 0;
      end
    end
  end

endmodule
